//--- list.f
+incdir+verif
logic/pcie_tlp_pkg.sv
logic/mmio_map_pkg.sv
logic/mmio_rx_bridge.sv
logic/mmio_csr_regs.sv
logic/mmio_cpl_builder.sv
logic/mmio_subsystem.sv
verif/mmio_tb.sv

//--- Makefile
# Verilator build and run of the MMIO subsystem testbench

VERILATOR ?= verilator
TOP       ?= mmio_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/mmio_model.svh
// Register file and pending completion model, included inside the MMIO testbench module
`ifndef MMIO_MODEL_SVH
`define MMIO_MODEL_SVH

logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] csr_model [mmio_map_pkg::CSR_COUNT];
pcie_tlp_pkg::tlp_cpl_hdr_t              pending_hdr_q [$];
logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] pending_data_q [$];

function automatic void clear_model();
    for (int r = 0; r < mmio_map_pkg::CSR_COUNT; r++)
        csr_model[r] = '0;
endfunction

// CplD header expected for one read request
function automatic pcie_tlp_pkg::tlp_cpl_hdr_t expected_cpl_hdr(
    input logic [9:0]  tag,
    input logic [15:0] req_id,
    input logic [9:0]  len_dw,
    input logic [6:0]  low_addr
);
    pcie_tlp_pkg::tlp_cpl_hdr_t hdr;
    hdr            = '0;
    hdr.fmt_type   = pcie_tlp_pkg::cpl_d;
    hdr.length     = len_dw;
    hdr.cpl_id     = pcie_tlp_pkg::CPL_COMPLETER_ID;
    hdr.byte_count = {len_dw, 2'b00};
    hdr.req_id     = req_id;
    hdr.tag        = tag;
    hdr.lower_addr = low_addr;
    return hdr;
endfunction

// Applies one accepted request beat to the model
function automatic void apply_request(input logic [511:0] beat);
    pcie_tlp_pkg::tlp_req_hdr_t              hdr;
    logic [63:0]                             addr;
    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] payload;
    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] rdata;
    int                                      idx;
    int                                      off;
    int                                      nbytes;
    hdr     = beat[255:0];
    payload = beat[256 +: mmio_map_pkg::BUS_DATA_WIDTH];
    case (hdr.fmt_type)
        pcie_tlp_pkg::mem_rd32, pcie_tlp_pkg::mem_wr32:
            addr = {32'd0, hdr.addr_h};
        pcie_tlp_pkg::mem_rd64, pcie_tlp_pkg::mem_wr64:
            addr = {hdr.addr_h, hdr.addr_l, 2'b00};
        default:
            return;
    endcase
    idx    = int'(addr[6:3]);
    off    = int'(addr[2:0]);
    nbytes = 4 * int'(hdr.length);
    if (hdr.fmt_type == pcie_tlp_pkg::mem_wr32 || hdr.fmt_type == pcie_tlp_pkg::mem_wr64)
    begin
        // Payload byte k lands on lane off+k, lanes past the register are lost
        for (int k = 0; k < nbytes; k++)
        begin
            if (off + k < mmio_map_pkg::BUS_BE_WIDTH)
                csr_model[idx][8*(off+k) +: 8] = payload[8*k +: 8];
        end
    end
    else
    begin
        rdata = '0;
        for (int k = 0; off + k < mmio_map_pkg::BUS_BE_WIDTH; k++)
            rdata[8*k +: 8] = csr_model[idx][8*(off+k) +: 8];
        pending_hdr_q.push_back(expected_cpl_hdr(hdr.tag, hdr.req_id, hdr.length, addr[6:0]));
        pending_data_q.push_back(rdata);
    end
endfunction

`endif

//--- verif/mmio_tb.sv
// MMIO slave path testbench that checks random request beats against a register file model
`default_nettype none
`timescale 1ns/1ns

module mmio_tb;

    localparam int BEAT_COUNT    = 300;
    localparam int WRITE_WARMUP  = 32;
    localparam int RX_TIMEOUT    = 200;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int FILL_WIDTH    = 256 - mmio_map_pkg::BUS_DATA_WIDTH;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         rx_valid;
    logic         rx_sop;
    logic         rx_eop;
    logic [511:0] rx_data;
    logic         rx_ready;
    logic         cpl_valid;
    logic [511:0] cpl_data;
    logic         cpl_sop;
    logic         cpl_eop;
    logic         tx_ready = 1'b0;
    logic         heavy_bp = 1'b0;
    integer       seed = 32'h2691_b03d;
    logic [511:0] beat_q [$];

    `include "mmio_model.svh"

    always #5 clk = ~clk;

    mmio_subsystem mmio_subsystem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_sop    (rx_sop),
        .rx_eop    (rx_eop),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .cpl_valid (cpl_valid),
        .cpl_data  (cpl_data),
        .cpl_sop   (cpl_sop),
        .cpl_eop   (cpl_eop),
        .tx_ready  (tx_ready)
    );

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------
    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_cpl_hdr(input pcie_tlp_pkg::tlp_cpl_hdr_t got,
                                   input pcie_tlp_pkg::tlp_cpl_hdr_t exp);
        if (got !== exp)
        begin
            $display("ERR cpl_data[255:0] got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    task automatic compare_cpl_data(input logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] got,
                                    input logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR cpl_data[319:256] got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    // Read data is zero-extended over the rest of the upper half
    task automatic compare_cpl_fill(input logic [FILL_WIDTH-1:0] got);
        logic [FILL_WIDTH-1:0] exp;
        exp = '0;
        if (got !== exp)
        begin
            $display("ERR cpl_data[511:320] got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    // Both streams observed mid-cycle where every DUT output is settled
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (cpl_valid)
            begin
                if (pending_hdr_q.size() == 0)
                begin
                    $display("Completion presented with no read pending");
                    abort_run();
                end
                compare_flag("cpl_sop", cpl_sop, 1'b1);
                compare_flag("cpl_eop", cpl_eop, 1'b1);
                if (tx_ready)
                begin
                    compare_cpl_hdr(cpl_data[255:0], pending_hdr_q.pop_front());
                    compare_cpl_data(cpl_data[256 +: 64], pending_data_q.pop_front());
                    compare_cpl_fill(cpl_data[511:320]);
                end
            end
            if (rx_valid && rx_ready)
                apply_request(rx_data);
            if (pending_hdr_q.size() > mmio_map_pkg::MAX_OUTSTANDING_READS)
            begin
                $display("Accepted reads without a sent completion exceed the limit");
                abort_run();
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    always @(posedge clk)
    begin
        logic ready_next;
        ready_next = heavy_bp ? (($random(seed) & 3) == 0) : (($random(seed) & 3) != 0);
        #1;
        tx_ready = ready_next;
    end

    function automatic logic [511:0] make_beat(input logic [7:0] fmt, input logic [63:0] addr);
        pcie_tlp_pkg::tlp_req_hdr_t hdr;
        logic [63:0]                payload;
        hdr          = '0;
        hdr.fmt_type = pcie_tlp_pkg::tlp_fmt_type_e'(fmt);
        hdr.length   = (($random(seed) & 1) != 0) ? 10'd2 : 10'd1;
        hdr.req_id   = $random(seed);
        hdr.tag      = $random(seed);
        hdr.first_be = 4'hf;
        hdr.last_be  = (hdr.length == 10'd2) ? 4'hf : 4'h0;
        if (fmt[5])
        begin
            hdr.addr_h = addr[63:32];
            hdr.addr_l = addr[31:2];
        end
        else
        begin
            // 32-bit form carries noise in addr_l
            hdr.addr_h = addr[31:0];
            hdr.addr_l = $random(seed);
        end
        payload = {$random(seed), $random(seed)};
        return {192'd0, payload, hdr};
    endfunction

    function automatic logic [511:0] random_beat(input bit writes_only);
        logic [3:0]  pick;
        logic [7:0]  fmt;
        logic [63:0] addr;
        bit          wide;
        pick      = $random(seed);
        wide      = $random(seed);
        addr      = {$random(seed), $random(seed)};
        addr[1:0] = 2'b00;
        if (writes_only || pick < 4'd6)
            fmt = wide ? pcie_tlp_pkg::mem_wr64 : pcie_tlp_pkg::mem_wr32;
        else if (pick < 4'd14)
            fmt = wide ? pcie_tlp_pkg::mem_rd64 : pcie_tlp_pkg::mem_rd32;
        else
        begin
            fmt = $random(seed);
            while (fmt inside {pcie_tlp_pkg::mem_rd32, pcie_tlp_pkg::mem_rd64,
                               pcie_tlp_pkg::mem_wr32, pcie_tlp_pkg::mem_wr64})
                fmt = $random(seed);
        end
        return make_beat(fmt, addr);
    endfunction

    task automatic wait_rx_ready();
        int waited;
        waited = 0;
        while (!rx_ready)
        begin
            @(negedge clk);
            waited++;
            if (waited > RX_TIMEOUT)
            begin
                $display("Timeout waiting for rx_ready after initialization");
                abort_run();
            end
        end
        @(posedge clk);
        #1;
    endtask

    // Holds one beat on the receive stream until it is taken
    task automatic send_beat(input logic [511:0] beat);
        int waited;
        bit taken;
        waited   = 0;
        taken    = 1'b0;
        rx_valid = 1'b1;
        rx_sop   = 1'b1;
        rx_eop   = 1'b1;
        rx_data  = beat;
        while (!taken)
        begin
            @(negedge clk);
            taken = rx_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited > RX_TIMEOUT)
            begin
                $display("Timeout waiting for rx_ready on a request beat");
                abort_run();
            end
        end
        rx_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_hdr_q.size() != 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT)
            begin
                $display("Timeout waiting for outstanding completions");
                abort_run();
            end
        end
    endtask

    initial
    begin
        rst_n    = 1'b0;
        rx_valid = 1'b0;
        rx_sop   = 1'b0;
        rx_eop   = 1'b0;
        rx_data  = '0;
        clear_model();
        for (int i = 0; i < BEAT_COUNT; i++)
            beat_q.push_back(random_beat(i < WRITE_WARMUP));

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Nothing moves while the register file initializes
        repeat (mmio_map_pkg::CSR_INIT_CYCLES)
        begin
            @(negedge clk);
            compare_flag("rx_ready", rx_ready, 1'b0);
            compare_flag("cpl_valid", cpl_valid, 1'b0);
        end
        wait_rx_ready();

        foreach (beat_q[i])
        begin
            // Second half runs against mostly stalled transmit
            if (i == BEAT_COUNT / 2)
                heavy_bp = 1'b1;
            send_beat(beat_q[i]);
        end
        heavy_bp = 1'b0;
        wait_drain();

        // Quiet tail where any stray completion is still caught
        repeat (20) @(posedge clk);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/mmio_subsystem.sv
// MMIO slave path top level, chains request bridge, register file and completion builder
`default_nettype none
`timescale 1ns/1ns

module mmio_subsystem (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          rx_valid,
    input  wire          rx_sop,
    input  wire          rx_eop,
    input  wire  [511:0] rx_data,
    output logic         rx_ready,
    output logic         cpl_valid,
    output logic [511:0] cpl_data,
    output logic         cpl_sop,
    output logic         cpl_eop,
    input  wire          tx_ready
);

    logic                                    bus_write;
    logic                                    bus_read;
    logic [mmio_map_pkg::BUS_ADDR_WIDTH-1:0] bus_address;
    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] bus_writedata;
    logic [mmio_map_pkg::BUS_BE_WIDTH-1:0]   bus_byteenable;
    logic                                    bus_waitrequest;
    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] bus_readdata;
    logic                                    bus_readdatavalid;
    logic                                    bus_writeresponsevalid;

    // Read sideband to the completion builder
    logic                                    rd_strb;
    logic [9:0]                              rd_tag;
    logic [15:0]                             rd_req_id;
    logic [pcie_tlp_pkg::CPL_BC_WIDTH-1:0]   rd_length;
    logic [mmio_map_pkg::BUS_ADDR_WIDTH-1:0] rd_low_addr;
    logic                                    cpl_sent;

    mmio_rx_bridge mmio_rx_bridge_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .rx_valid               (rx_valid),
        .rx_sop                 (rx_sop),
        .rx_eop                 (rx_eop),
        .rx_data                (rx_data),
        .rx_ready               (rx_ready),
        .bus_waitrequest        (bus_waitrequest),
        .bus_readdatavalid      (bus_readdatavalid),
        .bus_writeresponsevalid (bus_writeresponsevalid),
        .bus_write              (bus_write),
        .bus_read               (bus_read),
        .bus_address            (bus_address),
        .bus_writedata          (bus_writedata),
        .bus_byteenable         (bus_byteenable),
        .rd_strb                (rd_strb),
        .rd_tag                 (rd_tag),
        .rd_req_id              (rd_req_id),
        .rd_length              (rd_length),
        .rd_low_addr            (rd_low_addr),
        .cpl_sent               (cpl_sent)
    );

    mmio_csr_regs mmio_csr_regs_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .bus_write              (bus_write),
        .bus_read               (bus_read),
        .bus_address            (bus_address),
        .bus_writedata          (bus_writedata),
        .bus_byteenable         (bus_byteenable),
        .bus_waitrequest        (bus_waitrequest),
        .bus_readdata           (bus_readdata),
        .bus_readdatavalid      (bus_readdatavalid),
        .bus_writeresponsevalid (bus_writeresponsevalid)
    );

    mmio_cpl_builder mmio_cpl_builder_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_strb           (rd_strb),
        .rd_tag            (rd_tag),
        .rd_req_id         (rd_req_id),
        .rd_length         (rd_length),
        .rd_low_addr       (rd_low_addr),
        .bus_readdata      (bus_readdata),
        .bus_readdatavalid (bus_readdatavalid),
        .tx_ready          (tx_ready),
        .cpl_valid         (cpl_valid),
        .cpl_sop           (cpl_sop),
        .cpl_eop           (cpl_eop),
        .cpl_data          (cpl_data),
        .cpl_sent          (cpl_sent)
    );

endmodule

`default_nettype wire

//--- logic/mmio_cpl_builder.sv
// Completion builder, pairs read context with read data and sends CplD words
`default_nettype none
`timescale 1ns/1ns

module mmio_cpl_builder (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     rd_strb,
    input  wire  [9:0]                              rd_tag,
    input  wire  [15:0]                             rd_req_id,
    input  wire  [pcie_tlp_pkg::CPL_BC_WIDTH-1:0]   rd_length,
    input  wire  [mmio_map_pkg::BUS_ADDR_WIDTH-1:0] rd_low_addr,
    input  wire  [mmio_map_pkg::BUS_DATA_WIDTH-1:0] bus_readdata,
    input  wire                                     bus_readdatavalid,
    input  wire                                     tx_ready,
    output logic                                    cpl_valid,
    output logic                                    cpl_sop,
    output logic                                    cpl_eop,
    output logic [511:0]                            cpl_data,
    output logic                                    cpl_sent
);

    localparam int DEPTH = mmio_map_pkg::CPL_FIFO_DEPTH;

    logic [9:0]                              ctx_tag      [DEPTH];
    logic [15:0]                             ctx_req_id   [DEPTH];
    logic [pcie_tlp_pkg::CPL_BC_WIDTH-1:0]   ctx_length   [DEPTH];
    logic [mmio_map_pkg::BUS_ADDR_WIDTH-1:0] ctx_low_addr [DEPTH];
    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] rd_data      [DEPTH];
    logic [mmio_map_pkg::CPL_PTR_WIDTH-1:0]  ctx_wr_ptr;
    logic [mmio_map_pkg::CPL_PTR_WIDTH-1:0]  data_wr_ptr;
    logic [mmio_map_pkg::CPL_PTR_WIDTH-1:0]  rd_ptr;
    logic [mmio_map_pkg::CPL_COUNT_WIDTH-1:0] ctx_count;
    logic [mmio_map_pkg::CPL_COUNT_WIDTH-1:0] data_count;
    pcie_tlp_pkg::tlp_cpl_hdr_t              cpl_hdr;
    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] cpl_payload;

    // Queue pointers, both heads pop together
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctx_wr_ptr  <= '0;
            data_wr_ptr <= '0;
            rd_ptr      <= '0;
            ctx_count   <= '0;
            data_count  <= '0;
        end
        else
        begin
            if (rd_strb)
                ctx_wr_ptr <= ctx_wr_ptr + 1'b1;
            if (bus_readdatavalid)
                data_wr_ptr <= data_wr_ptr + 1'b1;
            if (cpl_sent)
                rd_ptr <= rd_ptr + 1'b1;
            if (rd_strb && !cpl_sent)
                ctx_count <= ctx_count + 1'b1;
            else if (!rd_strb && cpl_sent)
                ctx_count <= ctx_count - 1'b1;
            if (bus_readdatavalid && !cpl_sent)
                data_count <= data_count + 1'b1;
            else if (!bus_readdatavalid && cpl_sent)
                data_count <= data_count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_strb)
        begin
            ctx_tag[ctx_wr_ptr]      <= rd_tag;
            ctx_req_id[ctx_wr_ptr]   <= rd_req_id;
            ctx_length[ctx_wr_ptr]   <= rd_length;
            ctx_low_addr[ctx_wr_ptr] <= rd_low_addr;
        end
        if (bus_readdatavalid)
            rd_data[data_wr_ptr] <= bus_readdata;
    end

    // ------------------------------------------------------------------------
    // CplD word from the queue heads
    // ------------------------------------------------------------------------
    always_comb
    begin
        cpl_valid = (ctx_count != '0) && (data_count != '0);
        cpl_sent  = cpl_valid && tx_ready;
        cpl_sop   = cpl_valid;
        cpl_eop   = cpl_valid;

        cpl_hdr            = '0;
        cpl_hdr.fmt_type   = pcie_tlp_pkg::cpl_d;
        cpl_hdr.length     = ctx_length[rd_ptr][pcie_tlp_pkg::CPL_BC_WIDTH-1:2];
        cpl_hdr.cpl_id     = pcie_tlp_pkg::CPL_COMPLETER_ID;
        cpl_hdr.byte_count = ctx_length[rd_ptr];
        cpl_hdr.req_id     = ctx_req_id[rd_ptr];
        cpl_hdr.tag        = ctx_tag[rd_ptr];
        cpl_hdr.lower_addr = ctx_low_addr[rd_ptr];

        // Requested bytes start at the bottom of the payload
        cpl_payload = rd_data[rd_ptr] >> (8 * ctx_low_addr[rd_ptr][2:0]);
        cpl_data    = {{(256 - mmio_map_pkg::BUS_DATA_WIDTH){1'b0}}, cpl_payload, cpl_hdr};
    end

endmodule

`default_nettype wire

//--- logic/mmio_csr_regs.sv
// Control/status register file answering the register bus, with byte-enabled writes
`default_nettype none
`timescale 1ns/1ns

module mmio_csr_regs (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     bus_write,
    input  wire                                     bus_read,
    input  wire  [mmio_map_pkg::BUS_ADDR_WIDTH-1:0] bus_address,
    input  wire  [mmio_map_pkg::BUS_DATA_WIDTH-1:0] bus_writedata,
    input  wire  [mmio_map_pkg::BUS_BE_WIDTH-1:0]   bus_byteenable,
    output logic                                    bus_waitrequest,
    output logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] bus_readdata,
    output logic                                    bus_readdatavalid,
    output logic                                    bus_writeresponsevalid
);

    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0]   csr [mmio_map_pkg::CSR_COUNT];
    logic [mmio_map_pkg::INIT_COUNT_WIDTH-1:0] init_count;
    logic [mmio_map_pkg::CSR_INDEX_WIDTH-1:0]  csr_index;
    logic                                      wr_accept;
    logic                                      rd_accept;

    always_comb
    begin
        bus_waitrequest = (init_count != mmio_map_pkg::CSR_INIT_CYCLES);
        csr_index       = bus_address[mmio_map_pkg::BUS_ADDR_WIDTH-1:3];
        wr_accept       = bus_write && !bus_waitrequest;
        rd_accept       = bus_read && !bus_waitrequest;
    end

    // Initialization wait after reset
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            init_count <= '0;
        end
        else if (bus_waitrequest)
        begin
            init_count <= init_count + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < mmio_map_pkg::CSR_COUNT; r++)
                csr[r] <= '0;
        end
        else if (wr_accept)
        begin
            for (int b = 0; b < mmio_map_pkg::BUS_BE_WIDTH; b++)
            begin
                if (bus_byteenable[b])
                    csr[csr_index][8*b +: 8] <= bus_writedata[8*b +: 8];
            end
        end
    end

    // Responses, one cycle after the command
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bus_readdatavalid      <= 1'b0;
            bus_writeresponsevalid <= 1'b0;
        end
        else
        begin
            bus_readdatavalid      <= rd_accept;
            bus_writeresponsevalid <= wr_accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_accept)
            bus_readdata <= csr[csr_index];
    end

endmodule

`default_nettype wire

//--- logic/mmio_rx_bridge.sv
// Request bridge that turns single-beat memory request TLPs into register bus commands
`default_nettype none
`timescale 1ns/1ns

module mmio_rx_bridge (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     rx_valid,
    input  wire                                     rx_sop,
    input  wire                                     rx_eop,
    input  wire  [511:0]                            rx_data,
    output logic                                    rx_ready,
    input  wire                                     bus_waitrequest,
    input  wire                                     bus_readdatavalid,
    input  wire                                     bus_writeresponsevalid,
    output logic                                    bus_write,
    output logic                                    bus_read,
    output logic [mmio_map_pkg::BUS_ADDR_WIDTH-1:0] bus_address,
    output logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0] bus_writedata,
    output logic [mmio_map_pkg::BUS_BE_WIDTH-1:0]   bus_byteenable,
    output logic                                    rd_strb,
    output logic [9:0]                              rd_tag,
    output logic [15:0]                             rd_req_id,
    output logic [pcie_tlp_pkg::CPL_BC_WIDTH-1:0]   rd_length,
    output logic [mmio_map_pkg::BUS_ADDR_WIDTH-1:0] rd_low_addr,
    input  wire                                     cpl_sent
);

    typedef enum logic [2:0] {
        st_reset,
        st_ready,
        st_wait_rd_slot,
        st_wait_cpl,
        st_wait_wr,
        st_wait_resp
    } rx_state_e;

    rx_state_e                                   state;
    rx_state_e                                   state_next;
    logic                                        beat_valid;
    pcie_tlp_pkg::tlp_req_hdr_t                  hdr;
    logic [mmio_map_pkg::BUS_DATA_WIDTH-1:0]     payload;
    logic                                        is_read;
    logic                                        is_write;
    logic [63:0]                                 req_addr;
    logic [2:0]                                  byte_off;
    logic [pcie_tlp_pkg::CPL_BC_WIDTH-1:0]       len_bytes;
    logic [mmio_map_pkg::RD_COUNT_WIDTH-1:0]     rd_count;
    logic                                        rd_pending;
    logic                                        wr_hold;
    logic                                        beat_done;
    logic                                        rd_block;

    // ------------------------------------------------------------------------
    // Beat capture
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            beat_valid <= 1'b0;
        end
        else if (rx_valid && rx_ready)
        begin
            // Multi-beat TLPs are not supported
            beat_valid <= rx_sop && rx_eop;
        end
        else if (beat_done)
        begin
            beat_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_valid && rx_ready)
        begin
            hdr     <= rx_data[255:0];
            payload <= rx_data[256 +: mmio_map_pkg::BUS_DATA_WIDTH];
        end
    end

    // Format/type decode and address forming
    always_comb
    begin
        is_read  = 1'b0;
        is_write = 1'b0;
        req_addr = 64'd0;
        case (hdr.fmt_type)
            pcie_tlp_pkg::mem_rd32:
            begin
                is_read  = 1'b1;
                req_addr = {32'd0, hdr.addr_h};
            end
            pcie_tlp_pkg::mem_wr32:
            begin
                is_write = 1'b1;
                req_addr = {32'd0, hdr.addr_h};
            end
            pcie_tlp_pkg::mem_rd64:
            begin
                is_read  = 1'b1;
                req_addr = {hdr.addr_h, hdr.addr_l, 2'b00};
            end
            pcie_tlp_pkg::mem_wr64:
            begin
                is_write = 1'b1;
                req_addr = {hdr.addr_h, hdr.addr_l, 2'b00};
            end
            default:
            begin
                // Unsupported types are dropped without a bus cycle
                req_addr = 64'd0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Register bus command
    // ------------------------------------------------------------------------
    always_comb
    begin
        byte_off  = req_addr[2:0];
        len_bytes = {hdr.length, 2'b00};

        // Writes wait until earlier read data is back on the bus
        wr_hold   = rd_pending && !bus_readdatavalid;
        beat_done = beat_valid && !bus_waitrequest && !(is_write && wr_hold);

        bus_read       = beat_valid && is_read;
        bus_write      = beat_valid && is_write && !wr_hold;
        bus_address    = req_addr[mmio_map_pkg::BUS_ADDR_WIDTH-1:0];
        bus_writedata  = payload << (8 * byte_off);
        for (int i = 0; i < mmio_map_pkg::BUS_BE_WIDTH; i++)
        begin
            bus_byteenable[i] = (i >= byte_off) && (i < byte_off + len_bytes);
        end

        rd_strb     = bus_read && !bus_waitrequest;
        rd_tag      = hdr.tag;
        rd_req_id   = hdr.req_id;
        rd_length   = len_bytes;
        rd_low_addr = bus_address;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_pending <= 1'b0;
        end
        else if (rd_strb)
        begin
            rd_pending <= 1'b1;
        end
        else if (bus_readdatavalid)
        begin
            rd_pending <= 1'b0;
        end
    end

    // Reads whose completion has not yet left
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_count <= '0;
        end
        else
        begin
            case ({rd_strb, cpl_sent})
                2'b10:   rd_count <= rd_count + 1'b1;
                2'b01:   rd_count <= rd_count - 1'b1;
                default: rd_count <= rd_count;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Ready FSM
    // ------------------------------------------------------------------------
    // A write on the bus closes the receive stream until its response
    always_comb
    begin
        rd_block = beat_valid && is_read
                   && (rd_count + 2 >= mmio_map_pkg::MAX_OUTSTANDING_READS);
        rx_ready = (state == st_ready) && !rd_block && !bus_write
                   && !(beat_valid && !beat_done);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= st_reset;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_reset:
            begin
                if (!bus_waitrequest)
                    state_next = st_ready;
            end
            st_ready:
            begin
                if (bus_write)
                    state_next = bus_waitrequest ? st_wait_wr : st_wait_resp;
                else if (rd_block)
                    state_next = rd_strb ? st_wait_cpl : st_wait_rd_slot;
            end
            st_wait_rd_slot:
            begin
                if (rd_strb)
                    state_next = st_wait_cpl;
            end
            st_wait_cpl:
            begin
                if (cpl_sent)
                    state_next = st_ready;
            end
            st_wait_wr:
            begin
                if (bus_write && !bus_waitrequest)
                    state_next = st_wait_resp;
            end
            st_wait_resp:
            begin
                if (bus_writeresponsevalid)
                    state_next = st_ready;
            end
            default:
            begin
                state_next = st_reset;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/mmio_map_pkg.sv
// Register bus widths, register map size and buffering limits of the MMIO subsystem
`default_nettype none

package mmio_map_pkg;

    // Register bus
    localparam int BUS_ADDR_WIDTH = 7;
    localparam int BUS_DATA_WIDTH = 64;
    localparam int BUS_BE_WIDTH   = BUS_DATA_WIDTH / 8;

    // Register file
    localparam int CSR_COUNT        = 16;
    localparam int CSR_INDEX_WIDTH  = $clog2(CSR_COUNT);
    localparam int CSR_INIT_CYCLES  = 4;
    localparam int INIT_COUNT_WIDTH = $clog2(CSR_INIT_CYCLES + 1);

    // Completion buffering and read flow control
    localparam int CPL_FIFO_DEPTH        = 4;
    localparam int CPL_PTR_WIDTH         = $clog2(CPL_FIFO_DEPTH);
    localparam int CPL_COUNT_WIDTH       = $clog2(CPL_FIFO_DEPTH + 1);
    localparam int MAX_OUTSTANDING_READS = CPL_FIFO_DEPTH;
    localparam int RD_COUNT_WIDTH        = $clog2(MAX_OUTSTANDING_READS + 1);

endpackage

`default_nettype wire

//--- logic/pcie_tlp_pkg.sv
// TLP header layouts and format/type codes, used by the MMIO request and completion paths
`default_nettype none

package pcie_tlp_pkg;

    // Format/type byte of the TLPs handled by this endpoint
    typedef enum logic [7:0] {
        mem_rd32 = 8'h00,
        mem_rd64 = 8'h20,
        mem_wr32 = 8'h40,
        mem_wr64 = 8'h60,
        cpl_d    = 8'h4a
    } tlp_fmt_type_e;

    localparam int CPL_BC_WIDTH = 12;
    localparam logic [15:0] CPL_COMPLETER_ID = 16'h0100;

    // Request header, low half of a receive beat
    typedef struct packed {
        logic [141:0]  rsvd;
        logic [29:0]   addr_l;
        logic [31:0]   addr_h;
        logic [3:0]    last_be;
        logic [3:0]    first_be;
        logic [9:0]    tag;
        logic [15:0]   req_id;
        logic [9:0]    length;
        tlp_fmt_type_e fmt_type;
    } tlp_req_hdr_t;

    // Completion header, low half of a transmit beat
    typedef struct packed {
        logic [176:0]              rsvd;
        logic [6:0]                lower_addr;
        logic [9:0]                tag;
        logic [15:0]               req_id;
        logic [CPL_BC_WIDTH-1:0]   byte_count;
        logic [15:0]               cpl_id;
        logic [9:0]                length;
        tlp_fmt_type_e             fmt_type;
    } tlp_cpl_hdr_t;

endpackage

`default_nettype wire
